// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = gfx_tb
FILELIST = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q -F '** PASS **' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
hdl/gfx_cfg_pkg.sv
hdl/gfx_data_pkg.sv
hdl/gfx_column_counter.sv
hdl/gfx_renderer.sv
hdl/gfx_linebuf.sv
hdl/gfx_fetch_fsm.sv
hdl/gfx.sv
verification/gfx_checker.sv
verification/gfx_tb.sv

// ==== hdl/gfx.sv ====
module gfx #(
    parameter int LINE_WIDTH   = gfx_cfg_pkg::LINE_WIDTH,
    parameter int SPRITE_COUNT = gfx_cfg_pkg::SPRITE_COUNT,
    parameter int VLINE_OFFSET = gfx_cfg_pkg::VLINE_OFFSET
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  gfx_cfg_pkg::gfx_mode_t               gfx_mode,
    input  logic                                 sprites_enable,
    input  logic [8:0]                           scrx,
    input  logic [7:0]                           scry,
    input  logic [7:0]                           vline,
    output logic [gfx_cfg_pkg::VRAM_ADDR_W-1:0]  vaddr,
    input  logic [15:0]                          vdata,
    output logic [5:0]                           spr_sel,
    input  gfx_data_pkg::sprite_attr_t           spr_attr,
    input  logic [gfx_cfg_pkg::XPOS_W-1:0]       linebuf_rdidx,
    output gfx_data_pkg::pixel_t                 linebuf_data,
    output logic                                 busy
);

    logic [5:0] col;
    logic [5:0] col_cnt;
    logic       spr_last;
    logic       cnt_load;
    logic       col_step;
    logic       spr_step;

    gfx_data_pkg::render_req_t req;
    logic render_start;
    logic render_busy;
    logic render_last_pixel;
    logic linesel;

    logic [gfx_cfg_pkg::XPOS_W-1:0] wridx;
    gfx_data_pkg::pixel_t           wrdata;
    logic                           wren;

    gfx_fetch_fsm #(
        .SPRITE_COUNT(SPRITE_COUNT),
        .VLINE_OFFSET(VLINE_OFFSET)
    ) i_fetch_fsm (
        .clk(clk), .reset(reset), .start(start), .gfx_mode(gfx_mode),
        .sprites_enable(sprites_enable), .scrx(scrx), .scry(scry), .vline(vline),
        .vdata(vdata), .spr_attr(spr_attr), .col(col), .col_cnt(col_cnt),
        .spr_sel(spr_sel), .spr_last(spr_last), .render_busy(render_busy),
        .render_last_pixel(render_last_pixel), .vaddr(vaddr), .cnt_load(cnt_load),
        .col_step(col_step), .spr_step(spr_step), .req(req),
        .render_start(render_start), .linesel(linesel), .busy(busy)
    );

    gfx_column_counter i_column_counter (
        .clk(clk), .reset(reset), .load(cnt_load), .scrx(scrx),
        .col_step(col_step), .spr_step(spr_step), .col(col), .col_cnt(col_cnt),
        .spr_sel(spr_sel), .spr_last(spr_last)
    );

    gfx_renderer #(.LINE_WIDTH(LINE_WIDTH)) i_renderer (
        .clk(clk), .reset(reset), .req(req), .render_start(render_start),
        .busy(render_busy), .last_pixel(render_last_pixel),
        .wridx(wridx), .wrdata(wrdata), .wren(wren)
    );

    gfx_linebuf #(.LINE_WIDTH(LINE_WIDTH)) i_linebuf (
        .clk(clk), .linesel(linesel), .wridx(wridx), .wrdata(wrdata), .wren(wren),
        .rdidx(linebuf_rdidx), .rddata(linebuf_data)
    );

endmodule

// ==== hdl/gfx_cfg_pkg.sv ====
package gfx_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Display geometry
    //////////////////////////////////////////////////////////////////////

    // Visible pixels per line
    localparam int LINE_WIDTH = 320;

    // Width of a pixel position on the line
    localparam int XPOS_W = 9;

    // Map columns per line, one extra for the fine scroll
    localparam int TILE_COLUMNS = 41;

    // Entries in the sprite attribute table
    localparam int SPRITE_COUNT = 64;

    // First active video line
    localparam int VLINE_OFFSET = 15;

    // Video RAM word address width
    localparam int VRAM_ADDR_W = 13;

    //////////////////////////////////////////////////////////////////////
    // Background mode
    //////////////////////////////////////////////////////////////////////

    // Both bitmap codes render as disabled
    typedef enum logic [1:0] {
        mode_disabled = 2'b00,
        mode_tile     = 2'b01,
        mode_bm1      = 2'b10,
        mode_bm4      = 2'b11
    } gfx_mode_t;

endpackage

// ==== hdl/gfx_column_counter.sv ====
module gfx_column_counter (
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  logic [8:0] scrx,
    input  logic       col_step,
    input  logic       spr_step,
    output logic [5:0] col,
    output logic [5:0] col_cnt,
    output logic [5:0] spr_sel,
    output logic       spr_last
);

    logic [5:0] col_r;
    logic [5:0] col_cnt_r;
    // Extra top bit flags a full pass over the table
    logic [6:0] spr_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            col_r     <= 6'd0;
            col_cnt_r <= 6'd0;
            spr_r     <= 7'd0;
        end else if (load) begin
            col_r     <= scrx[8:3];
            col_cnt_r <= 6'd0;
            spr_r     <= 7'd0;
        end else begin
            // Map column wraps over 64
            if (col_step) begin
                col_r     <= col_r + 6'd1;
                col_cnt_r <= col_cnt_r + 6'd1;
            end
            if (spr_step && !spr_r[6])
                spr_r <= spr_r + 7'd1;
        end
    end

    assign col      = col_r;
    assign col_cnt  = col_cnt_r;
    assign spr_sel  = spr_r[5:0];
    assign spr_last = spr_r[6];

endmodule

// ==== hdl/gfx_data_pkg.sv ====
package gfx_data_pkg;

    // Tile map entry as stored in video RAM, bit 15 first
    typedef struct packed {
        logic [1:0] reserved_hi;
        logic [1:0] palette;
        logic       reserved;
        logic       vflip;
        logic       hflip;
        logic [8:0] tile_idx;
    } map_entry_t;

    // One sprite attribute table entry
    typedef struct packed {
        logic [gfx_cfg_pkg::XPOS_W-1:0] x;
        logic [7:0]                     y;
        logic [8:0]                     idx;
        logic                           enable;
        logic                           priority_bit;
        logic [1:0]                     palette;
        logic                           h16;
        logic                           vflip;
        logic                           hflip;
        logic                           reserved;
    } sprite_attr_t;

    // Eight pixels for the renderer, pixel 0 in the top nibble
    typedef struct packed {
        logic [31:0]                    data;
        logic [gfx_cfg_pkg::XPOS_W-1:0] idx;
        logic                           is_sprite;
        logic                           hflip;
        logic [1:0]                     palette;
    } render_req_t;

    // Line buffer pixel
    typedef struct packed {
        logic [1:0] palette;
        logic [3:0] color;
    } pixel_t;

endpackage

// ==== hdl/gfx_fetch_fsm.sv ====
module gfx_fetch_fsm #(
    parameter int SPRITE_COUNT = 64,
    parameter int VLINE_OFFSET = 15
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  gfx_cfg_pkg::gfx_mode_t         gfx_mode,
    input  logic                           sprites_enable,
    input  logic [8:0]                     scrx,
    input  logic [7:0]                     scry,
    input  logic [7:0]                     vline,
    input  logic [15:0]                    vdata,
    input  gfx_data_pkg::sprite_attr_t     spr_attr,
    input  logic [5:0]                     col,
    input  logic [5:0]                     col_cnt,
    input  logic [5:0]                     spr_sel,
    input  logic                           spr_last,
    input  logic                           render_busy,
    input  logic                           render_last_pixel,
    output logic [gfx_cfg_pkg::VRAM_ADDR_W-1:0] vaddr,
    output logic                           cnt_load,
    output logic                           col_step,
    output logic                           spr_step,
    output gfx_data_pkg::render_req_t      req,
    output logic                           render_start,
    output logic                           linesel,
    output logic                           busy
);

    typedef enum logic [2:0] {
        st_done,
        st_map1,
        st_map2,
        st_pat1,
        st_pat2,
        st_spr
    } state_t;

    localparam logic [7:0] VOFS      = 8'(VLINE_OFFSET);
    localparam logic [6:0] SPR_END   = 7'(SPRITE_COUNT);
    localparam logic [5:0] LAST_COLS = 6'(gfx_cfg_pkg::TILE_COLUMNS);

    state_t state_r, state_next;
    state_t ret_r, ret_next;
    logic [gfx_cfg_pkg::VRAM_ADDR_W-1:0] vaddr_r, vaddr_next;
    gfx_data_pkg::render_req_t req_r, req_next;
    logic busy_r, busy_next;
    logic linesel_r, linesel_next;
    logic blank_r, blank_next;

    logic [7:0] line_idx;
    logic [7:0] tline;
    logic [15:0] vdata_eff;
    gfx_data_pkg::map_entry_t map_entry;
    logic [2:0] tile_line;
    logic renderer_free;

    logic [3:0] spr_height;
    logic [7:0] ydiff;
    logic spr_on_line;
    logic [3:0] spr_line;
    logic scan_end;

    assign line_idx  = vline - VOFS;
    assign tline     = line_idx + scry;

    // Disabled background reads as all zero
    assign vdata_eff = blank_r ? 16'h0000 : vdata;
    assign map_entry = vdata_eff;
    assign tile_line = map_entry.vflip ? ~tline[2:0] : tline[2:0];

    assign renderer_free = !render_busy || render_last_pixel;

    // Sprite visibility on this line
    assign spr_height  = spr_attr.h16 ? 4'd15 : 4'd7;
    assign ydiff       = line_idx - spr_attr.y;
    assign spr_on_line = spr_attr.enable && (ydiff <= {4'd0, spr_height});
    assign spr_line    = spr_attr.vflip ? (spr_height - ydiff[3:0]) : ydiff[3:0];
    assign scan_end    = spr_last || ({1'b0, spr_sel} >= SPR_END);

    //////////////////////////////////////////////////////////////////////
    // Fetch sequencing
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next   = state_r;
        ret_next     = ret_r;
        vaddr_next   = vaddr_r;
        req_next     = req_r;
        busy_next    = busy_r;
        linesel_next = linesel_r;
        blank_next   = blank_r;
        col_step     = 1'b0;
        spr_step     = 1'b0;
        render_start = 1'b0;

        if (start) begin
            busy_next          = 1'b1;
            linesel_next       = !linesel_r;
            blank_next         = (gfx_mode != gfx_cfg_pkg::mode_tile);
            state_next         = st_map1;
            req_next.is_sprite = 1'b0;
            req_next.idx       = (gfx_mode == gfx_cfg_pkg::mode_tile) ?
                                 (9'd0 - {6'd0, scrx[2:0]}) : 9'd0;
        end else if (busy_r) begin
            case (state_r)
                st_done: begin
                    if (!render_busy)
                        busy_next = 1'b0;
                end

                st_map1: begin
                    if (col_cnt == LAST_COLS) begin
                        blank_next = 1'b0;
                        state_next = sprites_enable ? st_spr : st_done;
                    end else begin
                        vaddr_next = {2'b00, tline[7:3], col};
                        state_next = st_map2;
                    end
                end

                st_map2: begin
                    vaddr_next       = {map_entry.tile_idx, tile_line, 1'b0};
                    req_next.hflip   = map_entry.hflip;
                    req_next.palette = map_entry.palette;
                    col_step         = 1'b1;
                    ret_next         = st_map1;
                    state_next       = st_pat1;
                end

                st_pat1: begin
                    req_next.data[31:24] = vdata_eff[7:0];
                    req_next.data[23:16] = vdata_eff[15:8];
                    vaddr_next[0]        = 1'b1;
                    state_next           = st_pat2;
                end

                st_pat2: begin
                    if (renderer_free) begin
                        req_next.data[15:8] = vdata_eff[7:0];
                        req_next.data[7:0]  = vdata_eff[15:8];
                        render_start        = 1'b1;
                        state_next          = ret_r;
                    end
                end

                st_spr: begin
                    req_next.is_sprite = 1'b1;
                    if (scan_end) begin
                        state_next = st_done;
                    end else begin
                        spr_step = 1'b1;
                        if (spr_on_line) begin
                            req_next.idx     = spr_attr.x;
                            req_next.hflip   = spr_attr.hflip;
                            req_next.palette = spr_attr.palette;
                            vaddr_next       = {spr_attr.idx[8:1],
                                                spr_attr.idx[0] ^ spr_line[3],
                                                spr_line[2:0], 1'b0};
                            ret_next         = st_spr;
                            state_next       = st_pat1;
                        end
                    end
                end

                default: state_next = st_done;
            endcase

            // Next tile lands 8 pixels further on
            if (render_start)
                req_next.idx = req_r.idx + 9'd8;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_r   <= st_done;
            ret_r     <= st_done;
            vaddr_r   <= '0;
            busy_r    <= 1'b0;
            linesel_r <= 1'b0;
            blank_r   <= 1'b0;
        end else begin
            state_r   <= state_next;
            ret_r     <= ret_next;
            vaddr_r   <= vaddr_next;
            busy_r    <= busy_next;
            linesel_r <= linesel_next;
            blank_r   <= blank_next;
        end
    end

    always_ff @(posedge clk) begin
        req_r <= req_next;
    end

    // Second pattern word goes straight through to the renderer
    always_comb begin
        req      = req_r;
        req.data = req_next.data;
    end

    assign vaddr    = vaddr_next;
    assign cnt_load = start;
    assign linesel  = linesel_r;
    assign busy     = busy_r;

endmodule

// ==== hdl/gfx_linebuf.sv ====
module gfx_linebuf #(
    parameter int LINE_WIDTH = 320
) (
    input  logic                           clk,
    input  logic                           linesel,
    input  logic [gfx_cfg_pkg::XPOS_W-1:0] wridx,
    input  gfx_data_pkg::pixel_t           wrdata,
    input  logic                           wren,
    input  logic [gfx_cfg_pkg::XPOS_W-1:0] rdidx,
    output gfx_data_pkg::pixel_t           rddata
);

    // Two halves, one per line
    gfx_data_pkg::pixel_t mem [2][LINE_WIDTH];

    always_ff @(posedge clk) begin
        if (wren)
            mem[linesel][wridx] <= wrdata;
    end

    // Display side reads the half not being drawn
    always_ff @(posedge clk) begin
        rddata <= mem[!linesel][rdidx];
    end

endmodule

// ==== hdl/gfx_renderer.sv ====
module gfx_renderer #(
    parameter int LINE_WIDTH = 320
) (
    input  logic                              clk,
    input  logic                              reset,
    input  gfx_data_pkg::render_req_t         req,
    input  logic                              render_start,
    output logic                              busy,
    output logic                              last_pixel,
    output logic [gfx_cfg_pkg::XPOS_W-1:0]    wridx,
    output gfx_data_pkg::pixel_t              wrdata,
    output logic                              wren
);

    gfx_data_pkg::render_req_t req_r;
    logic [2:0] cnt_r;
    logic       busy_r;

    logic [2:0] nib_sel;
    logic [3:0] color;
    logic [gfx_cfg_pkg::XPOS_W-1:0] pos;
    logic in_range;
    logic transparent;

    //////////////////////////////////////////////////////////////////////
    // Pixel counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_r <= 1'b0;
            cnt_r  <= 3'd0;
        end else if (render_start) begin
            busy_r <= 1'b1;
            cnt_r  <= 3'd0;
        end else if (busy_r) begin
            cnt_r <= cnt_r + 3'd1;
            if (cnt_r == 3'd7)
                busy_r <= 1'b0;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (render_start)
            req_r <= req;
    end

    //////////////////////////////////////////////////////////////////////
    // Pixel output
    //////////////////////////////////////////////////////////////////////

    // Mirrored order on hflip
    assign nib_sel = req_r.hflip ? ~cnt_r : cnt_r;
    assign color   = req_r.data[{~nib_sel, 2'b00} +: 4];
    assign pos     = req_r.idx + {6'd0, cnt_r};

    // Negative positions wrap to large values and are dropped here too
    assign in_range    = (pos < LINE_WIDTH);
    assign transparent = req_r.is_sprite && (color == 4'd0);

    assign wridx          = pos;
    assign wrdata.palette = req_r.palette;
    assign wrdata.color   = color;
    assign wren           = busy_r && in_range && !transparent;

    assign busy       = busy_r;
    assign last_pixel = busy_r && (cnt_r == 3'd7);

endmodule

// ==== verification/gfx_checker.sv ====
module gfx_checker #(
    parameter int LINE_WIDTH = 320
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           render_start,
    input logic                           busy,
    input logic                           last_pixel,
    input logic                           wren,
    input logic [gfx_cfg_pkg::XPOS_W-1:0] wridx
);

    // Write index steps by one through a request
    wridx_steps: assert property (@(posedge clk) disable iff (reset)
        (busy && !last_pixel && !render_start) |=> (wridx == $past(wridx) + 1'b1))
        else $error("line buffer write index did not advance by one");

    // A new request may only overlap the last pixel
    start_when_free: assert property (@(posedge clk) disable iff (reset)
        (render_start && busy) |-> last_pixel)
        else $error("render request arrived while the renderer was busy");

    idle_after_reset: assert property (@(posedge clk)
        reset |=> (!busy && !wren))
        else $error("renderer not idle after reset");

endmodule

// ==== verification/gfx_tb.sv ====
module gfx_tb;

    localparam int LINE_WIDTH     = gfx_cfg_pkg::LINE_WIDTH;
    localparam int ROWS           = 8;
    localparam int TIMEOUT_CYCLES = ROWS * 3000;

    // One test line, blank marks an expected all-zero background
    typedef struct packed {
        gfx_cfg_pkg::gfx_mode_t mode;
        logic [8:0]             scrx;
        logic [7:0]             scry;
        logic                   spr_en;
        logic [7:0]             vline;
        logic                   blank;
    } line_cfg_t;

    logic clk;
    logic reset;
    logic start;
    gfx_cfg_pkg::gfx_mode_t gfx_mode;
    logic sprites_enable;
    logic [8:0] scrx;
    logic [7:0] scry;
    logic [7:0] vline;
    logic [gfx_cfg_pkg::VRAM_ADDR_W-1:0] vaddr;
    logic [15:0] vdata = 16'h0000;
    logic [5:0] spr_sel;
    gfx_data_pkg::sprite_attr_t spr_attr;
    logic [gfx_cfg_pkg::XPOS_W-1:0] linebuf_rdidx;
    gfx_data_pkg::pixel_t linebuf_data;
    logic busy;

    logic [15:0] vram [8192];
    gfx_data_pkg::sprite_attr_t spr_table [64];
    gfx_data_pkg::pixel_t exp_line [LINE_WIDTH];
    int seed;
    int errors;
    int checks;

    line_cfg_t line_table [ROWS] = '{
        '{gfx_cfg_pkg::mode_tile,     9'd0,   8'd0,   1'b0, 8'd35,  1'b0},
        '{gfx_cfg_pkg::mode_tile,     9'd91,  8'd0,   1'b0, 8'd35,  1'b0},
        '{gfx_cfg_pkg::mode_tile,     9'd501, 8'd100, 1'b1, 8'd35,  1'b0},
        '{gfx_cfg_pkg::mode_disabled, 9'd167, 8'd0,   1'b1, 8'd35,  1'b1},
        '{gfx_cfg_pkg::mode_bm1,      9'd0,   8'd0,   1'b1, 8'd100, 1'b1},
        '{gfx_cfg_pkg::mode_bm4,      9'd0,   8'd0,   1'b0, 8'd100, 1'b1},
        '{gfx_cfg_pkg::mode_tile,     9'd7,   8'd200, 1'b1, 8'd100, 1'b0},
        '{gfx_cfg_pkg::mode_tile,     9'd300, 8'd37,  1'b1, 8'd150, 1'b0}
    };

    gfx i_gfx (
        .clk(clk), .reset(reset), .start(start), .gfx_mode(gfx_mode),
        .sprites_enable(sprites_enable), .scrx(scrx), .scry(scry), .vline(vline),
        .vaddr(vaddr), .vdata(vdata), .spr_sel(spr_sel), .spr_attr(spr_attr),
        .linebuf_rdidx(linebuf_rdidx), .linebuf_data(linebuf_data), .busy(busy)
    );

    bind gfx_renderer gfx_checker #(.LINE_WIDTH(LINE_WIDTH)) i_checker (
        .clk(clk), .reset(reset), .render_start(render_start), .busy(busy),
        .last_pixel(last_pixel), .wren(wren), .wridx(wridx)
    );

    // Video RAM answers one cycle late, sprite table at once
    always @(posedge clk) begin
        vdata <= vram[vaddr];
    end

    assign spr_attr = spr_table[spr_sel];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] pattern_data(input logic [12:0] addr);
        logic [15:0] w1;
        logic [15:0] w2;
        w1 = vram[addr];
        w2 = vram[addr | 13'd1];
        return {w1[7:0], w1[15:8], w2[7:0], w2[15:8]};
    endfunction

    task automatic draw_pixels(input logic [8:0] x0, input logic [31:0] data,
                               input logic hflip, input logic [1:0] pal,
                               input logic is_sprite);
        logic [8:0] pos;
        logic [3:0] color;
        for (int i = 0; i < 8; i++) begin
            pos   = x0 + 9'(i);
            color = hflip ? data[i*4 +: 4] : data[(7-i)*4 +: 4];
            // Colour 0 of a sprite shows what lies below
            if (pos < 9'(LINE_WIDTH) && !(is_sprite && color == 4'd0))
                exp_line[pos] = {pal, color};
        end
    endtask

    task automatic build_expected(input line_cfg_t cfg);
        logic [7:0] line_idx;
        logic [7:0] tline;
        logic [5:0] mcol;
        gfx_data_pkg::map_entry_t ent;
        logic [2:0] tl;
        logic [8:0] x0;
        logic [3:0] height;
        logic [7:0] ydiff;
        logic [3:0] sl;
        gfx_data_pkg::sprite_attr_t sp;
        line_idx = cfg.vline - 8'(gfx_cfg_pkg::VLINE_OFFSET);
        tline    = line_idx + cfg.scry;
        for (int c = 0; c < gfx_cfg_pkg::TILE_COLUMNS; c++) begin
            mcol = cfg.scrx[8:3] + 6'(c);
            ent  = cfg.blank ? 16'h0000 : vram[{2'b00, tline[7:3], mcol}];
            tl   = ent.vflip ? ~tline[2:0] : tline[2:0];
            x0   = 9'(c * 8) - (cfg.blank ? 9'd0 : {6'd0, cfg.scrx[2:0]});
            draw_pixels(x0, cfg.blank ? 32'h0 : pattern_data({ent.tile_idx, tl, 1'b0}),
                        ent.hflip, ent.palette, 1'b0);
        end
        for (int s = 0; s < 64 && cfg.spr_en; s++) begin
            sp     = spr_table[s];
            height = sp.h16 ? 4'd15 : 4'd7;
            ydiff  = line_idx - sp.y;
            if (sp.enable && ydiff <= {4'd0, height}) begin
                sl = sp.vflip ? height - ydiff[3:0] : ydiff[3:0];
                draw_pixels(sp.x, pattern_data({sp.idx[8:1], sp.idx[0] ^ sl[3], sl[2:0], 1'b0}),
                            sp.hflip, sp.palette, 1'b1);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic place_sprite(input int n, input int x, input int y, input int idx,
                                input logic h16, input logic vflip, input logic hflip,
                                input logic [1:0] pal, input logic en);
        spr_table[n].x       = 9'(x);
        spr_table[n].y       = 8'(y);
        spr_table[n].idx     = 9'(idx);
        spr_table[n].h16     = h16;
        spr_table[n].vflip   = vflip;
        spr_table[n].hflip   = hflip;
        spr_table[n].palette = pal;
        spr_table[n].enable  = en;
    endtask

    task automatic pulse_start(input line_cfg_t cfg);
        @(posedge clk);
        start          <= 1'b1;
        gfx_mode       <= cfg.mode;
        scrx           <= cfg.scrx;
        scry           <= cfg.scry;
        sprites_enable <= cfg.spr_en;
        vline          <= cfg.vline;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (!busy) begin
            errors++;
            $display("busy did not go high after start at time %0t", $time);
        end
    endtask

    task automatic wait_idle();
        while (busy)
            @(negedge clk);
    endtask

    // Read port is one cycle behind the index
    task automatic check_line();
        for (int j = 0; j <= LINE_WIDTH; j++) begin
            @(posedge clk);
            if (j < LINE_WIDTH)
                linebuf_rdidx <= 9'(j);
            @(negedge clk);
            if (j > 0) begin
                checks++;
                if (linebuf_data !== exp_line[j-1]) begin
                    errors++;
                    $display("Fail %0t: pixel %0d expected %h actual %h",
                             $time, j - 1, exp_line[j-1], linebuf_data);
                end
            end
        end
    endtask

    initial begin
        reset          = 1'b1;
        start          = 1'b0;
        gfx_mode       = gfx_cfg_pkg::mode_disabled;
        sprites_enable = 1'b0;
        scrx           = 9'd0;
        scry           = 8'd0;
        vline          = 8'd0;
        linebuf_rdidx  = 9'd0;
        errors         = 0;
        checks         = 0;
        seed           = 47142;
        for (int a = 0; a < 8192; a++)
            vram[a] = 16'($random(seed));
        for (int s = 0; s < 64; s++)
            spr_table[s] = {2'($random(seed)), 32'($random(seed))};
        // Sprites on line 20
        place_sprite(2, 50, 20, 9'h011, 1'b0, 1'b0, 1'b0, 2'd3, 1'b0);
        place_sprite(5, 30, 15, 9'h041, 1'b0, 1'b0, 1'b1, 2'd1, 1'b1);
        place_sprite(9, 34, 10, 9'h0a3, 1'b1, 1'b1, 1'b0, 2'd2, 1'b1);
        place_sprite(60, 315, 18, 9'h120, 1'b0, 1'b0, 1'b0, 2'd3, 1'b1);
        // Sprites on lines 85 and 135
        place_sprite(12, 100, 80, 9'h0c6, 1'b1, 1'b1, 1'b1, 2'd1, 1'b1);
        place_sprite(30, 104, 84, 9'h077, 1'b0, 1'b1, 1'b0, 2'd2, 1'b1);
        place_sprite(50, 316, 78, 9'h1f1, 1'b1, 1'b0, 1'b1, 2'd0, 1'b1);
        place_sprite(33, 0, 125, 9'h0d9, 1'b1, 1'b0, 1'b0, 2'd3, 1'b1);

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            pulse_start(line_table[r]);
            wait_idle();
            build_expected(line_table[r]);
            // Same line again so the finished half is on display
            pulse_start(line_table[r]);
            check_line();
            wait_idle();
        end

        $display("Checked %0d pixels, %0d errors", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
